// ==== rtl/demod_out_settings.svh ====
// Widths, address codes and select/mode codes for the demodulator output logic
// Host addresses are 16-bit word addresses, addr[11:1]; register words are 32 bits
// Reset stretch must be at least 1

`ifndef DEMOD_OUT_SETTINGS_SVH
`define DEMOD_OUT_SETTINGS_SVH

// Bus and datapath widths
`define DO_ADDR_W            11
`define DO_DATA_W            16
`define DO_SAMPLE_W          18
`define DO_DAC_W             14
`define DO_RAW_W             14
`define DO_SEL_W             4
`define DO_MODE_W            4
`define DO_NUM_DAC           3

// Miscellaneous space, byte addresses 0x800 to 0x80f
`define DO_MISC_SPACE_MASK   11'h7f8
`define DO_MISC_SPACE_MATCH  11'h400
`define DO_MISC_RESET_ADDR   10'h200   // 32-bit word address, addr[11:2]
`define DO_MISC_VERSION_ADDR 10'h201

`define DO_VERSION           16'h0079
`define DO_RESET_STRETCH     6         // Cycles of reset after the cause ends

// DAC select codes that take the trellis tap
`define DO_SEL_TRELLIS_I     4'd0
`define DO_SEL_TRELLIS_Q     4'd1
`define DO_SEL_TRELLIS_PHERR 4'd2
`define DO_SEL_TRELLIS_INDEX 4'd3

// Demodulator modes
`define DO_MODE_MULTIH       4'd1
`define DO_MODE_AUQPSK       4'd5
`define DO_MODE_SOQPSK       4'd6

`endif

// ==== rtl/demod_out_pkg.sv ====
// Packed bus types shared by the output logic and its testbench
// Field widths come from the settings header

`include "demod_out_settings.svh"

package demod_out_pkg;

  //**************************************************************************
  // Host register bus
  //**************************************************************************

  // Plain level strobes, sampled on the rising clock edge
  typedef struct packed {
    logic                  cs;
    logic                  rd;
    logic                  we;
    logic [`DO_ADDR_W-1:0] addr;    // addr[11:1] of the processor bus
    logic [`DO_DATA_W-1:0] wdata;
  } host_bus_t;

  //**************************************************************************
  // Sample and symbol streams
  //**************************************************************************

  // Trellis debug tap for one DAC
  typedef struct packed {
    logic                    sync;  // Sample valid
    logic [`DO_SAMPLE_W-1:0] sample;
  } dac_tap_t;

  // Symbol enable with its I and Q decisions
  typedef struct packed {
    logic sym_en;
    logic bit_i;
    logic bit_q;
  } sym_stream_t;

  // One clock/data pin pair
  typedef struct packed {
    logic clk;
    logic dat;
  } pin_pair_t;

endpackage

// ==== rtl/host_regs.sv ====
// Host register decode and board reset generation
// Reads are combinational and return zero outside the version register
// Any write to the reset word starts a soft reset, the data is ignored

`timescale 1ns/1ps
`include "demod_out_settings.svh"

module host_regs import demod_out_pkg::*; (
  input  logic                  ck933,
  input  logic                  rs,
  input  host_bus_t             bus_i,
  output logic [`DO_DATA_W-1:0] rd_data_o,
  output logic                  sys_reset_o
);

  localparam int CNT_W = $clog2(`DO_RESET_STRETCH + 1);
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`DO_RESET_STRETCH - 1);

  logic                      misc_hit;
  logic [`DO_ADDR_W-2:0]     word_addr;
  logic                      half_sel;
  logic [2*`DO_DATA_W-1:0]   misc_word;
  logic                      soft_wr;
  logic                      soft_q;
  logic [CNT_W-1:0]          stretch_cnt;
  logic                      reset_q;

  //**************************************************************************
  // Address decode
  //**************************************************************************

  assign misc_hit  = (bus_i.addr & `DO_MISC_SPACE_MASK) == `DO_MISC_SPACE_MATCH;
  assign word_addr = bus_i.addr[`DO_ADDR_W-1:1];
  assign half_sel  = bus_i.addr[0];     // addr[1], upper 16 bits

  // 32-bit register word, only the version is readable
  always_comb begin
    misc_word = '0;
    if (misc_hit && (word_addr == `DO_MISC_VERSION_ADDR)) begin
      misc_word = {`DO_VERSION, {`DO_DATA_W{1'b0}}};
    end
  end

  always_comb begin
    rd_data_o = '0;
    if (bus_i.cs && bus_i.rd) begin
      rd_data_o = half_sel ? misc_word[2*`DO_DATA_W-1:`DO_DATA_W]
                           : misc_word[`DO_DATA_W-1:0];
    end
  end

  assign soft_wr = bus_i.cs && bus_i.we && misc_hit &&
                   (word_addr == `DO_MISC_RESET_ADDR);

  //**************************************************************************
  // Reset stretcher
  //**************************************************************************

  // Soft reset strobe, one cycle behind the write
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      soft_q <= 1'b0;
    end else begin
      soft_q <= soft_wr;
    end
  end

  // Counter reloads on either cause; reset drops once it has run out
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      stretch_cnt <= CNT_LOAD;
      reset_q     <= 1'b1;
    end else if (soft_q) begin
      stretch_cnt <= CNT_LOAD;
      reset_q     <= 1'b1;
    end else begin
      reset_q <= (stretch_cnt != '0);
      if (stretch_cnt != '0) begin
        stretch_cnt <= stretch_cnt - CNT_W'(1);
      end
    end
  end

  assign sys_reset_o = reset_q;  // Also the board reset pin

endmodule

// ==== rtl/dac_channel.sv ====
// One DAC output channel with source select and offset-binary pin register
// Raw samples are zero-extended to 18 bits, so the pins see raw[13:4]
// Pins update only on a registered sync; latency is 2 cycles

`timescale 1ns/1ps
`include "demod_out_settings.svh"

module dac_channel import demod_out_pkg::*; (
  input  logic                 ck933,
  input  logic                 rs,
  input  logic                 sys_reset_i,
  input  logic [`DO_SEL_W-1:0] select_i,
  input  dac_tap_t             tap_i,
  input  logic [`DO_RAW_W-1:0] raw_i,
  output logic [`DO_DAC_W-1:0] dac_d_o
);

  logic                    trellis_sel;
  dac_tap_t                pick;
  logic [`DO_SAMPLE_W-1:0] sample_q;
  logic                    sync_q;

  //**************************************************************************
  // Source select
  //**************************************************************************

  always_comb begin
    case (select_i)
      `DO_SEL_TRELLIS_I,
      `DO_SEL_TRELLIS_Q,
      `DO_SEL_TRELLIS_PHERR,
      `DO_SEL_TRELLIS_INDEX: trellis_sel = 1'b1;
      default:               trellis_sel = 1'b0;
    endcase
  end

  always_comb begin
    if (trellis_sel) begin
      pick = tap_i;
    end else begin
      pick.sync   = 1'b1;    // Raw samples are valid every cycle
      pick.sample = {{(`DO_SAMPLE_W-`DO_RAW_W){1'b0}}, raw_i};
    end
  end

  // Registered choice
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      sync_q <= 1'b0;
    end else begin
      sync_q <= pick.sync;
    end
  end

  always_ff @(posedge ck933) begin
    sample_q <= pick.sample;
  end

  //**************************************************************************
  // Pin register
  //**************************************************************************

  // Top 14 bits with the sign flipped, two's complement to offset binary
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      dac_d_o <= '0;
    end else if (sys_reset_i) begin
      dac_d_o <= '0;
    end else if (sync_q) begin
      dac_d_o <= {~sample_q[`DO_SAMPLE_W-1],
                  sample_q[`DO_SAMPLE_W-2 -: `DO_DAC_W-1]};
    end
  end

endmodule

// ==== rtl/serial_out_mux.sv ====
// Clock/data pin pairs selected by demodulator mode
// Direct outputs: each pair is registered one cycle from its source
// Unknown mode codes fall back to the data stream

`timescale 1ns/1ps
`include "demod_out_settings.svh"

module serial_out_mux import demod_out_pkg::*; (
  input  logic                  ck933,
  input  logic                  rs,
  input  logic                  sys_reset_i,
  input  logic [`DO_MODE_W-1:0] mode_i,
  input  sym_stream_t           multih_i,
  input  sym_stream_t           data_i,
  input  logic                  au_sym_clk_i,
  output pin_pair_t             pair_i_o,
  output pin_pair_t             pair_q_o
);

  pin_pair_t next_i;
  pin_pair_t next_q;

  //**************************************************************************
  // Mode select
  //**************************************************************************

  // I pair, trellis decisions only in multi-h mode
  always_comb begin
    if (mode_i == `DO_MODE_MULTIH) begin
      next_i.clk = multih_i.sym_en;
      next_i.dat = multih_i.bit_i;
    end else begin
      next_i.clk = data_i.sym_en;
      next_i.dat = data_i.bit_i;
    end
  end

  always_comb begin
    case (mode_i)
      `DO_MODE_AUQPSK: begin
        next_q.clk = au_sym_clk_i;     // Separate Q symbol clock
        next_q.dat = data_i.bit_q;
      end
      `DO_MODE_SOQPSK,
      `DO_MODE_MULTIH: begin
        next_q.clk = multih_i.sym_en;
        next_q.dat = multih_i.bit_q;
      end
      default: begin
        next_q.clk = data_i.sym_en;
        next_q.dat = data_i.bit_q;
      end
    endcase
  end

  //**************************************************************************
  // Pin registers
  //**************************************************************************

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      pair_i_o <= '0;
      pair_q_o <= '0;
    end else if (sys_reset_i) begin
      pair_i_o <= '0;
      pair_q_o <= '0;
    end else begin
      pair_i_o <= next_i;
      pair_q_o <= next_q;
    end
  end

endmodule

// ==== rtl/demod_out_top.sv ====
// Host-facing and pin-facing logic of the multi-mode demodulator
// Trellis taps and the multi-h symbol stream arrive as inputs
// All blocks run on ck933; dac_rst_o is the stretched system reset

`timescale 1ns/1ps
`include "demod_out_settings.svh"

module demod_out_top import demod_out_pkg::*; (
  input  logic                                   ck933,
  input  logic                                   rs,
  // Host bus
  input  host_bus_t                              bus_i,
  output logic [`DO_DATA_W-1:0]                  rd_data_o,
  output logic                                   dac_rst_o,
  // DAC channels
  input  logic [`DO_MODE_W-1:0]                  mode_i,
  input  logic [`DO_NUM_DAC-1:0][`DO_SEL_W-1:0]  dac_select_i,
  input  dac_tap_t [`DO_NUM_DAC-1:0]             dac_tap_i,
  input  logic [`DO_NUM_DAC-1:0][`DO_RAW_W-1:0]  dac_raw_i,
  // Symbol streams
  input  sym_stream_t                            multih_i,
  input  sym_stream_t                            data_i,
  input  logic                                   au_sym_clk_i,
  output logic [`DO_NUM_DAC-1:0][`DO_DAC_W-1:0]  dac_d_o,
  output pin_pair_t                              pair_i_o,
  output pin_pair_t                              pair_q_o
);

  logic sys_reset;

  //**************************************************************************
  // Host registers and reset
  //**************************************************************************

  host_regs i_host_regs (
    .ck933       (ck933),
    .rs          (rs),
    .bus_i       (bus_i),
    .rd_data_o   (rd_data_o),
    .sys_reset_o (sys_reset)
  );

  assign dac_rst_o = sys_reset;

  //**************************************************************************
  // DAC outputs
  //**************************************************************************

  for (genvar d = 0; d < `DO_NUM_DAC; d++) begin : g_dac
    dac_channel i_dac_channel (
      .ck933       (ck933),
      .rs          (rs),
      .sys_reset_i (sys_reset),
      .select_i    (dac_select_i[d]),
      .tap_i       (dac_tap_i[d]),
      .raw_i       (dac_raw_i[d]),
      .dac_d_o     (dac_d_o[d])
    );
  end

  //**************************************************************************
  // Serial outputs
  //**************************************************************************

  serial_out_mux i_serial_out_mux (
    .ck933        (ck933),
    .rs           (rs),
    .sys_reset_i  (sys_reset),
    .mode_i       (mode_i),
    .multih_i     (multih_i),
    .data_i       (data_i),
    .au_sym_clk_i (au_sym_clk_i),
    .pair_i_o     (pair_i_o),
    .pair_q_o     (pair_q_o)
  );

endmodule

// ==== tests/demod_out_asserts.sv ====
// Concurrent checks on reset and DAC pins, bound into demod_out_top

`timescale 1ns/1ps
`include "demod_out_settings.svh"

module demod_out_asserts import demod_out_pkg::*; (
  input logic                                  ck933,
  input logic                                  rs,
  input logic                                  dac_rst_o,
  input logic [`DO_NUM_DAC-1:0][`DO_SEL_W-1:0] dac_select_i,
  input dac_tap_t [`DO_NUM_DAC-1:0]            dac_tap_i,
  input logic [`DO_NUM_DAC-1:0][`DO_DAC_W-1:0] dac_d_o
);

  a_reset_in_rs: assert property (@(posedge ck933) rs |-> dac_rst_o)
    else $error("board reset low while rs is high");

  // Pins cleared one edge after reset is seen
  a_dac_zero: assert property (@(posedge ck933) dac_rst_o |=> (dac_d_o == '0))
    else $error("DAC pins not zero during reset");

  // Sync registered one edge before the pin update it gates
  for (genvar d = 0; d < `DO_NUM_DAC; d++) begin : g_hold
    a_hold: assert property (@(posedge ck933) disable iff (rs)
      (!$past(dac_rst_o) && $past(dac_select_i[d] <= `DO_SEL_TRELLIS_INDEX, 2) &&
       !$past(dac_tap_i[d].sync, 2)) |-> (dac_d_o[d] == $past(dac_d_o[d])))
      else $error("DAC pins changed while sync was low");
  end

endmodule

bind demod_out_top demod_out_asserts i_demod_out_asserts (
  .ck933        (ck933),
  .rs           (rs),
  .dac_rst_o    (dac_rst_o),
  .dac_select_i (dac_select_i),
  .dac_tap_i    (dac_tap_i),
  .dac_d_o      (dac_d_o)
);

// ==== tests/demod_out_tb.sv ====
// Testbench for demod_out_top, random stimulus checked against a cycle model
// Inputs change 1 ns after the rising edge, outputs are checked 1 ns after it
// The first error stops the run

`timescale 1ns/1ps
`include "demod_out_settings.svh"

module demod_out_tb import demod_out_pkg::*; ();

  localparam int RESET_CYCLES  = 10;
  localparam int RANDOM_CYCLES = 2000;
  localparam int DIRECTED      = 60;   // Upper bound on the directed steps
  localparam int TIMEOUT       = RESET_CYCLES + DIRECTED + RANDOM_CYCLES + 100;

  logic ck933;
  logic rs;
  host_bus_t                             bus;
  logic [`DO_DATA_W-1:0]                 rd_data;
  logic                                  dac_rst;
  logic [`DO_MODE_W-1:0]                 mode;
  logic [`DO_NUM_DAC-1:0][`DO_SEL_W-1:0] sel;
  dac_tap_t [`DO_NUM_DAC-1:0]            tap;
  logic [`DO_NUM_DAC-1:0][`DO_RAW_W-1:0] raw;
  sym_stream_t                           multih;
  sym_stream_t                           data;
  logic                                  au_clk;
  logic [`DO_NUM_DAC-1:0][`DO_DAC_W-1:0] dac_d;
  pin_pair_t                             pair_i;
  pin_pair_t                             pair_q;

  // Model state
  logic [`DO_NUM_DAC-1:0]                   m_sync_q;
  logic [`DO_NUM_DAC-1:0][`DO_SAMPLE_W-1:0] m_sample_q;
  logic [`DO_NUM_DAC-1:0][`DO_DAC_W-1:0]    m_dac;
  pin_pair_t m_pi;
  pin_pair_t m_pq;
  int        m_rem;      // Reset cycles still to run
  logic      m_soft_q;

  logic [31:0] rng_state = 32'd70947;
  int          cycle_count = 0;
  int          error_count = 0;
  int          high_cycles;

  demod_out_top i_demod_out_top (
    .ck933 (ck933), .rs (rs), .bus_i (bus), .rd_data_o (rd_data), .dac_rst_o (dac_rst),
    .mode_i (mode), .dac_select_i (sel), .dac_tap_i (tap), .dac_raw_i (raw),
    .multih_i (multih), .data_i (data), .au_sym_clk_i (au_clk),
    .dac_d_o (dac_d), .pair_i_o (pair_i), .pair_q_o (pair_q)
  );

  always #10 ck933 = ~ck933;

  always @(posedge ck933) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT) begin
      $display("Timeout: the test did not finish within %0d cycles", TIMEOUT);
      $display("Simulation FAILED");
      $fatal(1, "run stopped on timeout");
    end
  end

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  //**************************************************************************
  // Compare tasks
  //**************************************************************************

  task automatic fail_now(input string msg);
    error_count++;
    $display("MISMATCH at %0t ns: %s", $time, msg);
    $display("Simulation FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic check_rd(input logic [`DO_DATA_W-1:0] got, input logic [`DO_DATA_W-1:0] exp);
    if (got !== exp) fail_now($sformatf("rd_data got %h expected %h", got, exp));
  endtask

  task automatic check_dac(input int d, input logic [`DO_DAC_W-1:0] got,
                           input logic [`DO_DAC_W-1:0] exp);
    if (got !== exp) fail_now($sformatf("dac %0d got %h expected %h", d, got, exp));
  endtask

  task automatic check_pair(input string name, input pin_pair_t got, input pin_pair_t exp);
    if (got !== exp) fail_now($sformatf("pair %s got %b expected %b", name, got, exp));
  endtask

  task automatic check_reset(input logic got, input logic exp);
    if (got !== exp) fail_now($sformatf("dac_rst got %b expected %b", got, exp));
  endtask

  //**************************************************************************
  // Reference model
  //**************************************************************************

  function automatic logic [`DO_DATA_W-1:0] expect_rd(input host_bus_t b);
    // Version sits on the upper half of its word, everything else reads zero
    if (b.cs && b.rd && b.addr == {`DO_MISC_VERSION_ADDR, 1'b1}) return `DO_VERSION;
    return '0;
  endfunction

  function automatic logic [`DO_DAC_W-1:0] offset_bin(input logic [`DO_SAMPLE_W-1:0] s);
    return s[`DO_SAMPLE_W-1 -: `DO_DAC_W] ^ {1'b1, {(`DO_DAC_W-1){1'b0}}};
  endfunction

  task automatic model_edge();
    logic reset_pre;
    reset_pre = (m_rem > 0);
    for (int d = 0; d < `DO_NUM_DAC; d++) begin
      if (reset_pre) m_dac[d] = '0;
      else if (m_sync_q[d]) m_dac[d] = offset_bin(m_sample_q[d]);
      if (sel[d] < 4) begin       // Trellis tap codes 0 to 3
        m_sync_q[d]   = tap[d].sync;
        m_sample_q[d] = tap[d].sample;
      end else begin
        m_sync_q[d]   = 1'b1;
        m_sample_q[d] = {4'b0000, raw[d]};
      end
    end
    if (reset_pre) begin
      m_pi = '0;
      m_pq = '0;
    end else begin
      m_pi = (mode == `DO_MODE_MULTIH) ? {multih.sym_en, multih.bit_i}
                                       : {data.sym_en, data.bit_i};
      if (mode == `DO_MODE_AUQPSK) m_pq = {au_clk, data.bit_q};
      else if (mode == `DO_MODE_SOQPSK || mode == `DO_MODE_MULTIH)
        m_pq = {multih.sym_en, multih.bit_q};
      else m_pq = {data.sym_en, data.bit_q};
    end
    if (m_soft_q) m_rem = `DO_RESET_STRETCH;
    else if (m_rem > 0) m_rem = m_rem - 1;
    m_soft_q = bus.cs && bus.we && (bus.addr[`DO_ADDR_W-1:1] == `DO_MISC_RESET_ADDR);
  endtask

  // One clock edge, then compare the registered outputs
  task automatic step();
    @(posedge ck933);
    model_edge();
    #1;
    check_reset(dac_rst, m_rem > 0);
    for (int d = 0; d < `DO_NUM_DAC; d++) check_dac(d, dac_d[d], m_dac[d]);
    check_pair("i", pair_i, m_pi);
    check_pair("q", pair_q, m_pq);
  endtask

  //**************************************************************************
  // Stimulus
  //**************************************************************************

  task automatic drive_datapath();
    logic [31:0] r;
    for (int d = 0; d < `DO_NUM_DAC; d++) begin
      r = xorshift32();
      sel[d] = r[3:0];
      raw[d] = r[31:18];
      r = xorshift32();
      tap[d].sync   = r[31];
      tap[d].sample = r[17:0];
    end
    r = xorshift32();
    case (r[1:0])
      2'd0:    mode = `DO_MODE_MULTIH;
      2'd1:    mode = `DO_MODE_AUQPSK;
      2'd2:    mode = `DO_MODE_SOQPSK;
      default: mode = r[7:4];
    endcase
    multih = r[10:8];
    data   = r[13:11];
    au_clk = r[14];
  endtask

  // Drive the bus, then check the combinational read
  task automatic drive_bus(input logic cs, input logic rd, input logic we,
                           input logic [`DO_ADDR_W-1:0] addr);
    logic [31:0] r;
    r = xorshift32();
    bus.cs    = cs;
    bus.rd    = rd;
    bus.we    = we;
    bus.addr  = addr;
    bus.wdata = r[31:16];
    #1;
    check_rd(rd_data, expect_rd(bus));
  endtask

  task automatic random_cycle();
    logic [31:0] r;
    logic [`DO_ADDR_W-1:0] a;
    r = xorshift32();
    a = r[26:16];
    if (r[9:8] == 2'd0) a = {`DO_MISC_VERSION_ADDR, r[10]};
    if (r[7:2] == 6'd0 && r[11]) a = {`DO_MISC_RESET_ADDR, r[12]};
    drive_datapath();
    drive_bus(r[0], r[1], r[7:2] == 6'd0, a);
    step();
  endtask

  initial begin
    ck933 = 1'b0;
    rs    = 1'b1;
    bus   = '0;
    mode  = '0;
    sel   = '0;
    tap   = '0;
    raw   = '0;
    multih = '0;
    data   = '0;
    au_clk = 1'b0;
    m_sync_q = '0;
    m_sample_q = '0;
    m_dac = '0;
    m_pi  = '0;
    m_pq  = '0;
    m_rem = `DO_RESET_STRETCH;
    m_soft_q = 1'b0;
    repeat (RESET_CYCLES) @(posedge ck933);
    #1 rs = 1'b0;

    // Stretch after release, counted in edges seen with reset high
    high_cycles = 0;
    for (int n = 0; n < 10; n++) begin
      if (dac_rst) high_cycles++;
      drive_datapath();
      step();
    end
    if (high_cycles != `DO_RESET_STRETCH) begin
      $display("Reset stretch lasted %0d cycles instead of %0d", high_cycles,
               `DO_RESET_STRETCH);
      fail_now("reset stretch length");
    end

    // Register reads
    drive_bus(1'b1, 1'b1, 1'b0, {`DO_MISC_VERSION_ADDR, 1'b1});
    check_rd(rd_data, `DO_VERSION);
    step();
    drive_bus(1'b1, 1'b1, 1'b0, {`DO_MISC_VERSION_ADDR, 1'b0});
    step();
    drive_bus(1'b1, 1'b1, 1'b0, 11'h123);
    step();
    drive_bus(1'b1, 1'b0, 1'b0, {`DO_MISC_VERSION_ADDR, 1'b1});
    step();
    drive_bus(1'b0, 1'b1, 1'b0, {`DO_MISC_VERSION_ADDR, 1'b1});
    step();

    // Soft reset, then a write elsewhere that must not reset
    drive_bus(1'b1, 1'b0, 1'b1, {`DO_MISC_RESET_ADDR, 1'b0});
    step();
    drive_bus(1'b0, 1'b0, 1'b0, '0);
    for (int n = 0; n < 12; n++) begin
      drive_datapath();
      step();
    end
    drive_bus(1'b1, 1'b0, 1'b1, {`DO_MISC_VERSION_ADDR, 1'b0});
    step();
    drive_bus(1'b0, 1'b0, 1'b0, '0);
    for (int n = 0; n < 4; n++) begin
      drive_datapath();
      step();
    end

    for (int n = 0; n < RANDOM_CYCLES; n++) random_cycle();

    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+rtl
rtl/demod_out_pkg.sv
rtl/host_regs.sv
rtl/dac_channel.sv
rtl/serial_out_mux.sv
rtl/demod_out_top.sv
tests/demod_out_asserts.sv
tests/demod_out_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the demodulator output testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module demod_out_tb \
  -Mdir obj_dir \
  -o Vdemod_out_tb

./obj_dir/Vdemod_out_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation PASSED$" sim.log; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail"
  exit 1
fi
